/* verilog/dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Geometry of the direct-mapped data cache.
// An address splits, from the top, into tag, index, word offset and byte bits.

// Selects one word inside a block.
`define DC_OFFSET_BITS 2

// Selects one of the sets.
`define DC_INDEX_BITS 4

// Whatever is left above index, offset and the two byte bits.
`define DC_TAG_BITS 24

`define DC_WORDS 4 // Words per block.

`define DC_SETS 16 // Number of sets, one block each.

`endif

/* verilog/dcache_pkg.sv */
`include "dcache_params.svh"

package dcache_pkg;

    // One 32-bit word of data or address.
    typedef logic [31:0] data_word_t;

    // An address word as the cache sees it.
    // The raw view goes to memory and back to the requester.
    // The field view picks the set, the word in the block and the tag to compare.
    typedef union packed {
        data_word_t raw;
        struct packed {
            logic [`DC_TAG_BITS-1:0]    tag;      // Compared against the stored tag.
            logic [`DC_INDEX_BITS-1:0]  index;    // Set select.
            logic [`DC_OFFSET_BITS-1:0] offset;   // Word within the block.
            logic [1:0]                 byte_sel; // Always zero, accesses are whole words.
        } fields;
    } cache_addr_u;

endpackage : dcache_pkg

/* verilog/cache_tag_store.sv */
`timescale 1ns/1ns
`include "dcache_params.svh"

module cache_tag_store (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    input  logic                      read_i,        // Read the set on the next edge.
    input  logic [`DC_INDEX_BITS-1:0] index_i,       // Set shared by read and write.
    input  logic [`DC_TAG_BITS-1:0]   compare_tag_i, // Tag of the pending request.

    input  logic                      write_i,       // Allocate the set, valid and clean.
    input  logic [`DC_TAG_BITS-1:0]   write_tag_i,
    input  logic                      set_dirty_i,   // Mark the set dirty after a store.

    output logic [`DC_TAG_BITS-1:0]   tag_o,
    output logic                      valid_o,
    output logic                      dirty_o,
    output logic                      hit_o
);

    // One tag per set. The tag alone means nothing until its valid bit is set.
    logic [`DC_TAG_BITS-1:0] tag_mem [`DC_SETS];

    // Status bits live in flops so that reset can clear every set at once.
    logic [`DC_SETS-1:0] valid_bits;
    logic [`DC_SETS-1:0] dirty_bits;

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            tag_mem[index_i] <= write_tag_i;
        end

        // Registered read, so the result shows up one cycle after the strobe.
        if (read_i) begin
            tag_o <= tag_mem[index_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            valid_o    <= 1'b0;
            dirty_o    <= 1'b0;
        end else begin
            if (write_i) begin
                valid_bits[index_i] <= 1'b1; // Freshly filled block.
                dirty_bits[index_i] <= 1'b0; // Matches memory until a store lands.
            end else if (set_dirty_i) begin
                dirty_bits[index_i] <= 1'b1;
            end

            if (read_i) begin
                valid_o <= valid_bits[index_i];
                dirty_o <= dirty_bits[index_i];
            end
        end
    end

    // The compare tag is held by the controller, so the hit stays stable
    // for as long as the read result is held.
    assign hit_o = valid_o && (tag_o == compare_tag_i);

    // The controller allocates on the first fill word and marks dirty
    // on the last one or on a store hit, never both in one cycle.
    a_no_write_and_dirty: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(write_i && set_dirty_i)
    );

endmodule : cache_tag_store

/* verilog/cache_data_store.sv */
`timescale 1ns/1ns
`include "dcache_params.svh"

module cache_data_store
    import dcache_pkg::*;
(
    input  logic                       clk_i,

    input  logic                       read_i,   // Read one word on the next edge.
    input  logic [`DC_INDEX_BITS-1:0]  index_i,
    input  logic [`DC_OFFSET_BITS-1:0] offset_i,

    input  logic                       write_i,  // Write one word at the edge.
    input  data_word_t                 write_data_i,

    output data_word_t                 read_data_o
);

    // All blocks laid out flat, set after set.
    data_word_t data_mem [`DC_SETS * `DC_WORDS];

    // Set and word select together form the flat word address.
    logic [`DC_INDEX_BITS+`DC_OFFSET_BITS-1:0] word_addr;

    assign word_addr = {index_i, offset_i};

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            data_mem[word_addr] <= write_data_i;
        end

        // The read word is held until the next read strobe.
        // During write-back this is what feeds the memory store data.
        if (read_i) begin
            read_data_o <= data_mem[word_addr];
        end
    end

    // The controller never reads and writes the array in the same cycle.
    // A store hit writes in OUTCOME, and fills write only in ALLOCATE.
    a_no_read_and_write: assert property (
        @(posedge clk_i) !(read_i && write_i)
    );

endmodule : cache_data_store

/* verilog/cache_controller.sv */
`timescale 1ns/1ns
`include "dcache_params.svh"

module cache_controller
    import dcache_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    // Load/store unit side.
    input  logic                       request_i,
    input  logic                       write_i,
    input  cache_addr_u                address_i,
    input  data_word_t                 write_data_i,
    output data_word_t                 data_o,
    output logic                       valid_o,

    // Tag store side.
    output logic                       tag_read_o,
    output logic                       tag_write_o,
    output logic                       tag_set_dirty_o,
    output logic [`DC_INDEX_BITS-1:0]  index_o,
    output logic [`DC_TAG_BITS-1:0]    compare_tag_o,
    input  logic [`DC_TAG_BITS-1:0]    tag_i,
    input  logic                       dirty_i,
    input  logic                       hit_i,

    // Data store side.
    output logic                       data_read_o,
    output logic                       data_write_o,
    output logic [`DC_OFFSET_BITS-1:0] offset_o,
    output data_word_t                 data_store_o,
    input  data_word_t                 data_i,

    // Memory load channel.
    output logic                       mem_load_request_o,
    output data_word_t                 mem_load_address_o,
    input  logic                       mem_load_valid_i,
    input  data_word_t                 mem_load_data_i,

    // Memory store channel.
    output logic                       mem_store_request_o,
    output data_word_t                 mem_store_address_o,
    output data_word_t                 mem_store_data_o,
    input  logic                       mem_store_done_i
);

    localparam logic [1:0] IDLE       = 2'd0; // Waiting for a request.
    localparam logic [1:0] OUTCOME    = 2'd1; // Store results are back to decide hit or miss.
    localparam logic [1:0] WRITE_BACK = 2'd2; // Dirty victim goes out word by word.
    localparam logic [1:0] ALLOCATE   = 2'd3; // New block comes in from memory.

    logic [1:0] state_q, state_d;

    // Word counter. One bit wider than the offset so write-back can
    // count past the last word while the final store goes out.
    logic [`DC_OFFSET_BITS:0]   count_q, count_d;
    logic [`DC_OFFSET_BITS-1:0] word_sel; // Low bits of the counter.

    // Request captured in IDLE.
    cache_addr_u req_addr_q;
    logic        req_write_q;
    data_word_t  req_wdata_q;

    // Requested word, caught as it streams past during a fill.
    data_word_t req_word_q, req_word_d;

    // Victim and fill addresses built from the request fields.
    cache_addr_u victim_addr, fill_addr;

    assign word_sel = count_q[`DC_OFFSET_BITS-1:0];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            count_q <= '0;
        end else begin
            state_q <= state_d;
            count_q <= count_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && request_i) begin
            req_addr_q  <= address_i;
            req_write_q <= write_i;
            req_wdata_q <= write_data_i;
        end
        req_word_q <= req_word_d;
    end

    always_comb begin
        // The victim shares the set. Only the stored tag differs.
        victim_addr                 = req_addr_q;
        victim_addr.fields.tag      = tag_i;
        victim_addr.fields.offset   = word_sel - 1'b1; // Word read one cycle earlier.
        victim_addr.fields.byte_sel = 2'b00;

        fill_addr                 = req_addr_q;
        fill_addr.fields.offset   = '0; // Fills always start at the block base.
        fill_addr.fields.byte_sel = 2'b00;
    end

    assign mem_store_address_o = victim_addr.raw;
    assign mem_store_data_o    = data_i; // Registered data store output.
    assign mem_load_address_o  = fill_addr.raw;
    assign compare_tag_o       = req_addr_q.fields.tag; // Also the tag written on a fill.

    always_comb begin
        state_d    = state_q;
        count_d    = count_q;
        req_word_d = req_word_q;

        data_o  = '0;
        valid_o = 1'b0;

        tag_read_o      = 1'b0;
        tag_write_o     = 1'b0;
        tag_set_dirty_o = 1'b0;
        data_read_o     = 1'b0;
        data_write_o    = 1'b0;

        index_o      = req_addr_q.fields.index;
        offset_o     = req_addr_q.fields.offset;
        data_store_o = req_wdata_q;

        mem_load_request_o  = 1'b0;
        mem_store_request_o = 1'b0;

        case (state_q)
            IDLE: begin
                // Both stores look at the live address so results are ready next cycle.
                index_o  = address_i.fields.index;
                offset_o = address_i.fields.offset;
                count_d  = '0;

                if (request_i) begin
                    tag_read_o  = 1'b1;
                    data_read_o = 1'b1;
                    state_d     = OUTCOME;
                end
            end

            OUTCOME: begin
                if (hit_i) begin
                    valid_o = 1'b1;
                    state_d = IDLE;

                    if (req_write_q) begin
                        data_write_o    = 1'b1; // Word and offset come from the request.
                        tag_set_dirty_o = 1'b1;
                        data_o          = req_wdata_q; // Stores echo their data.
                    end else begin
                        data_o = data_i;
                    end
                end else if (dirty_i) begin
                    // Start the victim read at word zero; its store follows next cycle.
                    data_read_o = 1'b1;
                    offset_o    = '0;
                    count_d     = 1;
                    state_d     = WRITE_BACK;
                end else begin
                    mem_load_request_o = 1'b1; // A clean or empty set fetches straight away.
                    count_d            = '0;
                    state_d            = ALLOCATE;
                end
            end

            WRITE_BACK: begin
                offset_o = word_sel;

                // Counts 1 to 4 each send the word read in the cycle before.
                // Counts 1 to 3 also read the next one.
                if (count_q <= `DC_WORDS) begin
                    mem_store_request_o = 1'b1;
                    count_d             = count_q + 1'b1;
                    if (count_q < `DC_WORDS) begin
                        data_read_o = 1'b1;
                    end
                end

                if (mem_store_done_i) begin
                    mem_load_request_o = 1'b1; // The victim is safe in memory so fetch now.
                    count_d            = '0;
                    state_d            = ALLOCATE;
                end
            end

            ALLOCATE: begin
                offset_o     = word_sel;
                data_store_o = mem_load_data_i;

                if (mem_load_valid_i) begin
                    data_write_o = 1'b1;
                    count_d      = count_q + 1'b1;

                    if (word_sel == req_addr_q.fields.offset) begin
                        req_word_d = mem_load_data_i;
                        // A store merges its word into the fill instead of the memory copy.
                        if (req_write_q) begin
                            data_store_o = req_wdata_q;
                        end
                    end

                    if (count_q == '0) begin
                        tag_write_o = 1'b1; // Tag goes in with the first word.
                    end

                    if (count_q == `DC_WORDS - 1) begin
                        valid_o         = 1'b1;
                        state_d         = IDLE;
                        tag_set_dirty_o = req_write_q;

                        if (req_write_q) begin
                            data_o = req_wdata_q;
                        end else if (word_sel == req_addr_q.fields.offset) begin
                            data_o = mem_load_data_i; // Requested word is the last one.
                        end else begin
                            data_o = req_word_q;
                        end
                    end
                end
            end

            default: state_d = IDLE;
        endcase
    end

    // Every answer is a single pulse and the requester only asks again after it.
    a_valid_pulse: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) valid_o |=> !valid_o
    );

    // Memory returns fill words only while a fill is outstanding.
    a_load_in_allocate: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) mem_load_valid_i |-> state_q == ALLOCATE
    );

endmodule : cache_controller

/* verilog/dcache_top.sv */
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,

    // Load/store unit.
    input  logic        request_i,
    input  logic        write_i,
    input  cache_addr_u address_i,
    input  data_word_t  write_data_i,
    output data_word_t  data_o,
    output logic        valid_o,

    // Memory load channel.
    output logic        mem_load_request_o,
    output data_word_t  mem_load_address_o,
    input  logic        mem_load_valid_i,
    input  data_word_t  mem_load_data_i,

    // Memory store channel.
    output logic        mem_store_request_o,
    output data_word_t  mem_store_address_o,
    output data_word_t  mem_store_data_o,
    input  logic        mem_store_done_i
);

    // Controller to tag store.
    logic                       tag_read;
    logic                       tag_write;
    logic                       tag_set_dirty;
    logic [`DC_TAG_BITS-1:0]    compare_tag;
    logic [`DC_TAG_BITS-1:0]    stored_tag;
    logic                       stored_dirty;
    logic                       tag_hit;

    // Shared between both stores.
    logic [`DC_INDEX_BITS-1:0]  index;

    // Controller to data store.
    logic                       data_read;
    logic                       data_write;
    logic [`DC_OFFSET_BITS-1:0] offset;
    data_word_t                 store_word;
    data_word_t                 read_word;

    cache_tag_store u_tag_store (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .read_i        (tag_read),
        .index_i       (index),
        .compare_tag_i (compare_tag),
        .write_i       (tag_write),
        .write_tag_i   (compare_tag),  // A fill installs the requested tag.
        .set_dirty_i   (tag_set_dirty),
        .tag_o         (stored_tag),
        .valid_o       (),             // Already folded into hit_o.
        .dirty_o       (stored_dirty),
        .hit_o         (tag_hit)
    );

    cache_data_store u_data_store (
        .clk_i        (clk_i),
        .read_i       (data_read),
        .index_i      (index),
        .offset_i     (offset),
        .write_i      (data_write),
        .write_data_i (store_word),
        .read_data_o  (read_word)
    );

    cache_controller u_controller (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .request_i           (request_i),
        .write_i             (write_i),
        .address_i           (address_i),
        .write_data_i        (write_data_i),
        .data_o              (data_o),
        .valid_o             (valid_o),
        .tag_read_o          (tag_read),
        .tag_write_o         (tag_write),
        .tag_set_dirty_o     (tag_set_dirty),
        .index_o             (index),
        .compare_tag_o       (compare_tag),
        .tag_i               (stored_tag),
        .dirty_i             (stored_dirty),
        .hit_i               (tag_hit),
        .data_read_o         (data_read),
        .data_write_o        (data_write),
        .offset_o            (offset),
        .data_store_o        (store_word),
        .data_i              (read_word),
        .mem_load_request_o  (mem_load_request_o),
        .mem_load_address_o  (mem_load_address_o),
        .mem_load_valid_i    (mem_load_valid_i),
        .mem_load_data_i     (mem_load_data_i),
        .mem_store_request_o (mem_store_request_o),
        .mem_store_address_o (mem_store_address_o),
        .mem_store_data_o    (mem_store_data_o),
        .mem_store_done_i    (mem_store_done_i)
    );

endmodule : dcache_top

/* testbench/tb_memory_model.sv */
`timescale 1ns/1ns
`include "dcache_params.svh"

module tb_memory_model
    import dcache_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       load_request_i,  // One pulse per block fill.
    input  data_word_t load_address_i,  // Block base address.
    output logic       load_valid_o,    // One pulse per returned word.
    output data_word_t load_data_o,

    input  logic       store_request_i, // One pulse per written-back word.
    input  data_word_t store_address_i,
    input  data_word_t store_data_i,
    output logic       store_done_o     // Pulses once after the fourth word.
);

    data_word_t mem [data_word_t]; // Only words that were written back live here.

    data_word_t load_base;   // Base of the fill in progress.
    int         words_left;  // Fill words still to return.
    int         gap;         // Idle cycles before the next fill word.
    int         stores_seen; // Write-back words received so far.
    int         done_wait;   // Cycles until the done pulse, zero when none is pending.

    // Contents of a word that was never written. Every address bit feeds in.
    function automatic data_word_t initial_word(input data_word_t addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic data_word_t read_word(input data_word_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return initial_word(addr);
    endfunction

    initial begin
        load_valid_o = 1'b0;
        load_data_o  = '0;
        store_done_o = 1'b0;
        load_base    = '0;
        words_left   = 0;
        gap          = 0;
        stores_seen  = 0;
        done_wait    = 0;
        forever begin
            @(posedge clk_i); // Requests are taken at the edge.
            if (!rst_n_i) begin
                words_left  = 0;
                stores_seen = 0;
                done_wait   = 0;
            end else begin
                if (store_request_i) begin
                    mem[store_address_i] = store_data_i;
                    stores_seen++;
                    if (stores_seen == `DC_WORDS) begin
                        stores_seen = 0;
                        done_wait   = $urandom_range(1, 4); // Done comes some cycles later.
                    end
                end
                if (load_request_i) begin
                    load_base  = load_address_i;
                    words_left = `DC_WORDS;
                    gap        = $urandom_range(0, 3);
                end
            end

            #1; // Answers change a little after the edge, like the requester's inputs.
            store_done_o = 1'b0;
            load_valid_o = 1'b0;
            if (done_wait > 0) begin
                done_wait--;
                store_done_o = (done_wait == 0);
            end
            if (words_left > 0) begin
                if (gap > 0) begin
                    gap--; // Memory is slow this cycle.
                end else begin
                    load_valid_o = 1'b1;
                    load_data_o  = read_word(load_base
                                             + data_word_t'(4 * (`DC_WORDS - words_left)));
                    words_left--;
                    gap = $urandom_range(0, 2);
                end
            end
        end
    end

endmodule : tb_memory_model

/* testbench/tb_dcache.sv */
`timescale 1ns/1ns
`include "dcache_params.svh"

module tb_dcache
    import dcache_pkg::*;
();

    localparam int NUM_RANDOM     = 400; // Random accesses after the directed ones.
    localparam int ACCESS_TIMEOUT = 200; // Cycles one access may take at most.

    logic       clk_i;
    logic       rst_n_i;
    logic       request;
    logic       is_write;
    data_word_t address;
    data_word_t write_data;
    data_word_t read_data;
    logic       valid;
    logic       mem_load_request;
    data_word_t mem_load_address;
    logic       mem_load_valid;
    data_word_t mem_load_data;
    logic       mem_store_request;
    data_word_t mem_store_address;
    data_word_t mem_store_data;
    logic       mem_store_done;

    // Reference state. Word values by address, tag and status per set.
    data_word_t              ref_mem   [data_word_t];
    logic                    ref_valid [`DC_SETS];
    logic                    ref_dirty [`DC_SETS];
    logic [`DC_TAG_BITS-1:0] ref_tag   [`DC_SETS];
    logic [`DC_TAG_BITS-1:0] tag_pool  [3]; // Few tags so that sets conflict often.

    int hit_count;
    int store_hit_count;
    int clean_miss_count;
    int dirty_miss_count;

    dcache_top UUT (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .request_i (request), .write_i (is_write), .address_i (address),
        .write_data_i (write_data), .data_o (read_data), .valid_o (valid),
        .mem_load_request_o (mem_load_request), .mem_load_address_o (mem_load_address),
        .mem_load_valid_i (mem_load_valid), .mem_load_data_i (mem_load_data),
        .mem_store_request_o (mem_store_request), .mem_store_address_o (mem_store_address),
        .mem_store_data_o (mem_store_data), .mem_store_done_i (mem_store_done)
    );

    tb_memory_model u_memory (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .load_request_i (mem_load_request), .load_address_i (mem_load_address),
        .load_valid_o (mem_load_valid), .load_data_o (mem_load_data),
        .store_request_i (mem_store_request), .store_address_i (mem_store_address),
        .store_data_i (mem_store_data), .store_done_o (mem_store_done)
    );

    // Same start pattern as the backing memory. Any address bit changes it.
    function automatic data_word_t initial_word(input data_word_t addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic data_word_t expected_word(input data_word_t addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return initial_word(addr);
    endfunction

    function automatic data_word_t make_address(input logic [`DC_TAG_BITS-1:0] tag,
                                                input logic [`DC_INDEX_BITS-1:0] idx,
                                                input logic [`DC_OFFSET_BITS-1:0] offset);
        return {tag, idx, offset, 2'b00};
    endfunction

    task automatic finish_failed();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic stop_with_failure(input string what);
        $display("ERROR: %s", what);
        finish_failed();
    endtask

    task automatic report_mismatch(input string name, input data_word_t expected,
                                   input data_word_t actual);
        $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
        finish_failed();
    endtask

    // One request, watched cycle by cycle until valid_o, then the model is updated.
    task automatic run_access(input logic wr, input data_word_t addr, input data_word_t wdata);
        logic [`DC_INDEX_BITS-1:0] idx;
        logic [`DC_TAG_BITS-1:0]   tag;
        logic                      hit;
        logic                      victim_dirty;
        logic                      answered;
        data_word_t                expected;
        data_word_t                victim_addr;
        data_word_t                fill_addr;
        int                        cycle;
        int                        stores_seen;
        int                        loads_seen;

        idx          = addr[`DC_OFFSET_BITS+2 +: `DC_INDEX_BITS];
        tag          = addr[31 -: `DC_TAG_BITS];
        hit          = ref_valid[idx] && (ref_tag[idx] == tag);
        victim_dirty = !hit && ref_valid[idx] && ref_dirty[idx];
        expected     = wr ? wdata : expected_word(addr); // Stores echo their data.
        fill_addr    = make_address(tag, idx, '0);
        answered     = 1'b0;
        cycle        = 0;
        stores_seen  = 0;
        loads_seen   = 0;

        @(posedge clk_i);
        #1;
        request    = 1'b1;
        is_write   = wr;
        address    = addr;
        write_data = wdata;
        while (!answered) begin
            @(negedge clk_i); // All outputs have settled by mid-cycle.
            if (mem_store_request) begin
                victim_addr = make_address(ref_tag[idx], idx, stores_seen[`DC_OFFSET_BITS-1:0]);
                assert (victim_dirty && stores_seen < `DC_WORDS) else
                    stop_with_failure("store request to memory without a dirty victim");
                assert (mem_store_address == victim_addr) else
                    report_mismatch("write-back address", victim_addr, mem_store_address);
                assert (mem_store_data == expected_word(victim_addr)) else
                    report_mismatch("write-back data", expected_word(victim_addr), mem_store_data);
                stores_seen++;
            end
            if (mem_load_request) begin
                assert (!hit && loads_seen == 0) else
                    stop_with_failure("load request to memory that was not expected");
                assert (stores_seen == (victim_dirty ? `DC_WORDS : 0)) else
                    stop_with_failure("load request before the whole victim was written back");
                assert (mem_load_address == fill_addr) else
                    report_mismatch("fill address", fill_addr, mem_load_address);
                loads_seen++;
            end
            if (valid) begin
                answered = 1'b1;
                assert (loads_seen == (hit ? 0 : 1)) else
                    stop_with_failure("answer came without the expected block fill");
                assert (read_data == expected) else
                    report_mismatch(wr ? "store echo" : "load data", expected, read_data);
            end else begin
                cycle++;
                assert (!hit || cycle < 2) else
                    stop_with_failure("predicted hit did not answer in the cycle after the request");
                assert (cycle < ACCESS_TIMEOUT) else
                    stop_with_failure("no valid_o within the timeout after a request");
            end
            @(posedge clk_i);
            #1;
            request = 1'b0; // Request is a single-cycle pulse.
        end

        if (wr) begin
            ref_mem[addr] = wdata;
        end
        if (hit) begin
            hit_count++;
            if (wr) begin
                ref_dirty[idx] = 1'b1;
                store_hit_count++;
            end
        end else begin
            if (victim_dirty) begin
                dirty_miss_count++;
            end else begin
                clean_miss_count++;
            end
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = tag;
            ref_dirty[idx] = wr; // A store miss leaves the new block dirty.
        end
    endtask

    task automatic random_access();
        logic                       wr;
        logic [`DC_INDEX_BITS-1:0]  idx;
        logic [`DC_OFFSET_BITS-1:0] offset;
        data_word_t                 draw;
        data_word_t                 addr;

        draw   = $urandom(); // Low bits pick direction, set and word.
        wr     = draw[0];
        idx    = draw[1 +: `DC_INDEX_BITS];
        offset = draw[1 + `DC_INDEX_BITS +: `DC_OFFSET_BITS];
        addr   = make_address(tag_pool[$urandom_range(0, 2)], idx, offset);
        run_access(wr, addr, $urandom());
    endtask

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        void'($urandom(64174));
        rst_n_i    = 1'b0;
        request    = 1'b0;
        is_write   = 1'b0;
        address    = '0;
        write_data = '0;
        tag_pool[0] = 24'h00_0012;
        tag_pool[1] = 24'h0A_BC00;
        tag_pool[2] = 24'h7F_0031;
        for (int s = 0; s < `DC_SETS; s++) begin
            ref_valid[s] = 1'b0;
            ref_dirty[s] = 1'b0;
            ref_tag[s]   = '0;
        end
        hit_count        = 0;
        store_hit_count  = 0;
        clean_miss_count = 0;
        dirty_miss_count = 0;

        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // Quiet after reset while nothing is asked.
        repeat (10) begin
            @(negedge clk_i);
            assert (!valid && !mem_load_request && !mem_store_request) else
                stop_with_failure("output activity after reset without a request");
        end

        // Store, hit it, evict it dirty, then reload it through memory.
        run_access(1'b1, make_address(tag_pool[0], 4'd5, 2'd2), 32'hCAFE_0001);
        run_access(1'b0, make_address(tag_pool[0], 4'd5, 2'd2), '0);
        run_access(1'b0, make_address(tag_pool[1], 4'd5, 2'd0), '0);
        run_access(1'b0, make_address(tag_pool[0], 4'd5, 2'd2), '0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_access();
            repeat ($urandom_range(0, 2)) @(posedge clk_i); // Random idle gap.
        end

        assert (hit_count > 0 && store_hit_count > 0 && clean_miss_count > 0
                && dirty_miss_count > 0) else
            stop_with_failure("run missed a hit, a store hit, a clean miss or a dirty miss");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule : tb_dcache

/* dcache.f */
+incdir+verilog
verilog/dcache_pkg.sv
verilog/cache_tag_store.sv
verilog/cache_data_store.sv
verilog/cache_controller.sv
verilog/dcache_top.sv
testbench/tb_memory_model.sv
testbench/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcache_pkg.sv
      - verilog/cache_tag_store.sv
      - verilog/cache_data_store.sv
      - verilog/cache_controller.sv
      - verilog/dcache_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_memory_model.sv
      - testbench/tb_dcache.sv
